// ==== sin_macros.svh ====
`ifndef SIN_MACROS_SVH
`define SIN_MACROS_SVH

// q10.16 word width
`define SIN_W    27
// fraction bits, also the product shift
`define SIN_FRAC 16

// approx 4/pi in q10.16
`define SIN_C_1273 83443
// approx 4/pi^2 in q10.16
`define SIN_C_405  26561
// correction weight 0.225
`define SIN_C_225  14746

// axi4-lite bus geometry
`define AXI_DW 32
`define AXI_AW 4

// register map
`define REG_ANGLE  4'h0
`define REG_RESULT 4'h4
`define REG_COUNT  4'h8

`endif

// ==== sin_pkg.sv ====
`include "sin_macros.svh"

package sin_pkg;

	// signed q10.16 word
	typedef logic signed [`SIN_W-1:0] fix_t;

	// one datapath sample plus its occupancy flag
	typedef struct packed {
		logic valid;
		fix_t value;
	} fix_sample_t;

	// axi response codes in use here
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// fields driven by the manager
	typedef struct packed {
		logic [`AXI_AW-1:0]   awaddr;
		logic                 awvalid;
		logic [`AXI_DW-1:0]   wdata;
		logic [`AXI_DW/8-1:0] wstrb;
		logic                 wvalid;
		logic                 bready;
		logic [`AXI_AW-1:0]   araddr;
		logic                 arvalid;
		logic                 rready;
	} axil_req_t;

	// fields driven by the subordinate
	typedef struct packed {
		logic               awready;
		logic               wready;
		axil_resp_e         bresp;
		logic               bvalid;
		logic               arready;
		logic [`AXI_DW-1:0] rdata;
		axil_resp_e         rresp;
		logic               rvalid;
	} axil_rsp_t;

endpackage

// ==== fix_square.sv ====
`timescale 1ns/10ps
`include "sin_macros.svh"

module fix_square (
	input  logic          clk,
	input  logic          rst,
	input  sin_pkg::fix_t a,
	output sin_pkg::fix_t p
);

	// full signed product, twice the word width
	logic signed [2*`SIN_W-1:0] prod;
	// product scaled back to q10.16
	logic signed [2*`SIN_W-1:0] prod_shr;

	// both operands signed so they sign-extend before the multiply
	assign prod     = a * a;
	// arithmetic shift keeps the sign
	assign prod_shr = prod >>> `SIN_FRAC;

	// low word only, overflow bits dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			p <= '0;
		end else begin
			p <= prod_shr[`SIN_W-1:0];
		end
	end

endmodule

// ==== fix_mult_const.sv ====
`timescale 1ns/10ps
`include "sin_macros.svh"

module fix_mult_const #(
	// coefficient in q10.16, unity by default
	parameter sin_pkg::fix_t COEFF = (1 << `SIN_FRAC)
) (
	input  logic          clk,
	input  logic          rst,
	input  sin_pkg::fix_t a,
	output sin_pkg::fix_t p
);

	// full-width product against the constant
	logic signed [2*`SIN_W-1:0] prod;
	// rescaled product
	logic signed [2*`SIN_W-1:0] prod_shr;

	// signed times signed so no manual extension needed
	assign prod     = a * COEFF;
	assign prod_shr = prod >>> `SIN_FRAC;

	// truncate to one word and register
	always_ff @(posedge clk) begin
		if (rst) begin
			p <= '0;
		end else begin
			p <= prod_shr[`SIN_W-1:0];
		end
	end

endmodule

// ==== sin_pipe.sv ====
`timescale 1ns/10ps
`include "sin_macros.svh"

module sin_pipe (
	input  logic                 clk,
	input  logic                 rst,
	input  sin_pkg::fix_sample_t sample_in,
	output sin_pkg::fix_sample_t sample_out
);

	import sin_pkg::*;

	// occupancy per stage, bit 4 lines up with the output register
	logic [4:0] valid_sr;

	// stage 1 outputs
	fix_t angle_sq;
	fix_t angle_d1;

	// stage 2 outputs
	fix_t angle_sq_405;
	fix_t angle_1273;
	logic angle_neg_d2;
	// parabolic estimate, combinational off stage 2
	fix_t est;

	// stage 3 outputs
	fix_t est_sq;
	fix_t est_d1;

	// stage 4 inputs and outputs
	fix_t est_norm;
	fix_t norm_minus_est;
	fix_t corr_225;
	fix_t est_d2;

	// stage 5 result
	fix_t sin_q;

	// x * x
	fix_square i_angle_sq (
		.clk (clk),
		.rst (rst),
		.a   (sample_in.value),
		.p   (angle_sq)
	);

	// 0.405 * x * x
	fix_mult_const #(.COEFF(`SIN_C_405)) i_mul_405 (
		.clk (clk),
		.rst (rst),
		.a   (angle_sq),
		.p   (angle_sq_405)
	);

	// 1.273 * x, fed from the delayed angle so it lands with the 0.405 term
	fix_mult_const #(.COEFF(`SIN_C_1273)) i_mul_1273 (
		.clk (clk),
		.rst (rst),
		.a   (angle_d1),
		.p   (angle_1273)
	);

	// sign of x picks add or subtract
	assign est = angle_neg_d2 ? (angle_1273 + angle_sq_405) : (angle_1273 - angle_sq_405);

	// est * est
	fix_square i_est_sq (
		.clk (clk),
		.rst (rst),
		.a   (est),
		.p   (est_sq)
	);

	// square carries the sign of est
	assign est_norm       = est_d1[`SIN_W-1] ? -est_sq : est_sq;
	assign norm_minus_est = est_norm - est_d1;

	// 0.225 * (norm - est)
	fix_mult_const #(.COEFF(`SIN_C_225)) i_mul_225 (
		.clk (clk),
		.rst (rst),
		.a   (norm_minus_est),
		.p   (corr_225)
	);

	// valid bits march with the data
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[3:0], sample_in.valid};
		end
	end

	// operand alignment and final sum
	always_ff @(posedge clk) begin
		angle_d1     <= sample_in.value;
		angle_neg_d2 <= angle_d1[`SIN_W-1];
		est_d1       <= est;
		est_d2       <= est_d1;
		sin_q        <= corr_225 + est_d2;
	end

	assign sample_out = '{valid: valid_sr[4], value: sin_q};

endmodule

// ==== sin_axil_slave.sv ====
`timescale 1ns/10ps
`include "sin_macros.svh"

module sin_axil_slave (
	input  logic                 clk,
	input  logic                 rst,
	input  sin_pkg::axil_req_t   axil,
	output sin_pkg::axil_rsp_t   axil_rsp,
	output sin_pkg::fix_sample_t sample_in,
	input  sin_pkg::fix_sample_t sample_out
);

	import sin_pkg::*;

	// write channel
	logic       wr_fire;
	logic       wr_ok;
	logic       bvalid_q;
	axil_resp_e bresp_q;
	// sample launched toward the pipe
	logic       smp_valid_q;
	fix_t       smp_value_q;

	// read channel
	logic               rd_fire;
	axil_resp_e         rd_resp;
	logic [`AXI_DW-1:0] rd_data;
	logic               rvalid_q;
	axil_resp_e         rresp_q;
	logic [`AXI_DW-1:0] rdata_q;

	// last result and completion count
	fix_t        result_q;
	logic [15:0] count_q;

	// aw and w taken together, only with no response outstanding
	assign wr_fire = axil.awvalid && axil.wvalid && !bvalid_q;
	// only a full-word write to the angle register is legal
	assign wr_ok   = (axil.awaddr == `REG_ANGLE) && (&axil.wstrb);

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid_q    <= 1'b0;
			smp_valid_q <= 1'b0;
		end else begin
			// one-cycle pulse per accepted angle
			smp_valid_q <= wr_fire && wr_ok;
			if (wr_fire) begin
				bvalid_q <= 1'b1;
			end else if (axil.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// response code and angle word, held while bvalid waits
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp_q     <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			smp_value_q <= axil.wdata[`SIN_W-1:0];
		end
	end

	// read address accepted whenever no read data is pending
	assign rd_fire = axil.arvalid && !rvalid_q;

	// read decode
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (axil.araddr)
			`REG_RESULT: rd_data = {{(`AXI_DW-`SIN_W){result_q[`SIN_W-1]}}, result_q};
			`REG_COUNT:  rd_data = {{(`AXI_DW-16){1'b0}}, count_q};
			default:     rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid_q <= 1'b0;
		end else if (rd_fire) begin
			rvalid_q <= 1'b1;
		end else if (axil.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	// read payload frozen until rready
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata_q <= rd_data;
			rresp_q <= rd_resp;
		end
	end

	// newer result simply overwrites, count wraps at 16 bits
	always_ff @(posedge clk) begin
		if (rst) begin
			result_q <= '0;
			count_q  <= '0;
		end else if (sample_out.valid) begin
			result_q <= sample_out.value;
			count_q  <= count_q + 16'd1;
		end
	end

	// response side of the bus
	always_comb begin
		axil_rsp.awready = wr_fire;
		axil_rsp.wready  = wr_fire;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.arready = !rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
		axil_rsp.rvalid  = rvalid_q;
	end

	assign sample_in = '{valid: smp_valid_q, value: smp_value_q};

endmodule

// ==== sin_top.sv ====
`timescale 1ns/10ps

module sin_top (
	input  logic               clk,
	input  logic               rst,
	input  sin_pkg::axil_req_t axil,
	output sin_pkg::axil_rsp_t axil_rsp
);

	import sin_pkg::*;

	// angle samples into the datapath
	fix_sample_t sample_in;
	// finished sine values back to the registers
	fix_sample_t sample_out;

	// bus side, register map and result capture
	sin_axil_slave i_slave (
		.clk        (clk),
		.rst        (rst),
		.axil       (axil),
		.axil_rsp   (axil_rsp),
		.sample_in  (sample_in),
		.sample_out (sample_out)
	);

	// five-stage sine datapath
	// always accepts, never stalls
	sin_pipe i_pipe (
		.clk        (clk),
		.rst        (rst),
		.sample_in  (sample_in),
		.sample_out (sample_out)
	);

endmodule

// ==== tb_sin_top.sv ====
`timescale 1ns/10ps
`include "sin_macros.svh"

module tb_sin_top;

	import sin_pkg::*;

	localparam int WAIT_MAX = 64;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;
	// pi in q10.16 bounds the random angles
	localparam int PI_Q = 205887;

	logic clk = 1'b0;
	logic rst = 1'b1;
	axil_req_t req;
	axil_rsp_t rsp;
	integer seed = 69;

	sin_top i_dut (.clk(clk), .rst(rst), .axil(req), .axil_rsp(rsp));

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "stopped on first error");
	endtask

	task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, got);
			abort_run();
		end
	endtask

	// full product, arithmetic shift by the fraction bits, low word kept
	function automatic fix_t trunc_mul(input longint x, input longint y);
		longint full;
		full = (x * y) >>> `SIN_FRAC;
		return full[`SIN_W-1:0];
	endfunction

	// parabola plus 0.225 correction with every step wrapped to one word
	function automatic fix_t sine_model(input fix_t x);
		fix_t sq;
		fix_t est;
		fix_t est_sq;
		fix_t diff;
		sq = trunc_mul(x, x);
		if (x < 0) begin
			est = trunc_mul(x, `SIN_C_1273) + trunc_mul(sq, `SIN_C_405);
		end else begin
			est = trunc_mul(x, `SIN_C_1273) - trunc_mul(sq, `SIN_C_405);
		end
		est_sq = trunc_mul(est, est);
		diff = (est < 0) ? -est_sq : est_sq;
		diff = diff - est;
		return trunc_mul(diff, `SIN_C_225) + est;
	endfunction

	function automatic logic [31:0] sext(input fix_t v);
		return {{(`AXI_DW-`SIN_W){v[`SIN_W-1]}}, v};
	endfunction

	function automatic logic flag(input int which);
		case (which)
			0: return rsp.awready;
			1: return rsp.arready;
			2: return rsp.bvalid;
			default: return rsp.rvalid;
		endcase
	endfunction

	// readies seen at the rising edge and valids at the falling edge
	task automatic wait_flag(input int which, input string name);
		int n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < WAIT_MAX && !seen; n++) begin
			if (which < 2) begin
				@(posedge clk);
			end
			seen = flag(which);
			if (!seen && which >= 2) begin
				@(negedge clk);
			end
		end
		assert (seen) else begin
			$display("timeout while waiting for %s", name);
			abort_run();
		end
	endtask

	// ends on a falling edge with bvalid up
	task automatic send_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		@(negedge clk);
		req.awaddr = addr;
		req.wdata = data;
		req.wstrb = strb;
		req.awvalid = 1'b1;
		req.wvalid = 1'b1;
		wait_flag(0, "awready");
		// aw and w accepted on the same edge
		check_hex("wready", 32'd1, rsp.wready);
		@(negedge clk);
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		wait_flag(2, "bvalid");
	endtask

	task automatic send_read(input logic [3:0] addr);
		@(negedge clk);
		req.araddr = addr;
		req.arvalid = 1'b1;
		wait_flag(1, "arready");
		@(negedge clk);
		req.arvalid = 1'b0;
		wait_flag(3, "rvalid");
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		send_write(addr, data, strb);
		resp = rsp.bresp;
		@(posedge clk);
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		send_read(addr);
		data = rsp.rdata;
		resp = rsp.rresp;
		@(posedge clk);
	endtask

	task automatic get_count(output logic [15:0] c);
		logic [31:0] d;
		logic [1:0] r;
		axil_read(`REG_COUNT, d, r);
		check_hex("rresp", OKAY, r);
		c = d[15:0];
	endtask

	// poll the count register
	task automatic wait_count(input logic [15:0] target);
		int n;
		logic [15:0] c;
		c = target - 16'd1;
		for (n = 0; n < WAIT_MAX && c != target; n++) begin
			get_count(c);
		end
		assert (c == target) else begin
			$display("timeout while waiting for the count to reach %0d", target);
			abort_run();
		end
	endtask

	task automatic check_result(input fix_t x);
		logic [31:0] d;
		logic [1:0] r;
		axil_read(`REG_RESULT, d, r);
		check_hex("rresp", OKAY, r);
		check_hex("rdata", sext(sine_model(x)), d);
	endtask

	task automatic check_angle(input fix_t x);
		logic [15:0] c;
		logic [1:0] r;
		get_count(c);
		axil_write(`REG_ANGLE, sext(x), 4'hf, r);
		check_hex("bresp", OKAY, r);
		wait_count(c + 16'd1);
		check_result(x);
	endtask

	task automatic test_reset();
		logic [31:0] d;
		logic [1:0] r;
		check_hex("bvalid", 32'd0, rsp.bvalid);
		check_hex("rvalid", 32'd0, rsp.rvalid);
		axil_read(`REG_RESULT, d, r);
		check_hex("rresp", OKAY, r);
		check_hex("rdata", 32'd0, d);
		axil_read(`REG_COUNT, d, r);
		check_hex("rresp", OKAY, r);
		check_hex("rdata", 32'd0, d);
	endtask

	task automatic test_random(input int num);
		int i;
		fix_t x;
		for (i = 0; i < num; i++) begin
			x = $random(seed) % (PI_Q + 1);
			check_angle(x);
		end
	endtask

	// five writes, no polling in between
	task automatic test_burst();
		int i;
		fix_t x;
		logic [15:0] c;
		logic [1:0] r;
		get_count(c);
		for (i = 0; i < 5; i++) begin
			x = $random(seed) % (PI_Q + 1);
			axil_write(`REG_ANGLE, sext(x), 4'hf, r);
			check_hex("bresp", OKAY, r);
		end
		wait_count(c + 16'd5);
		check_result(x);
	endtask

	task automatic test_backpressure();
		int i;
		logic [15:0] c;
		logic [31:0] held_d;
		logic [1:0] held_r;
		get_count(c);
		@(negedge clk);
		req.bready = 1'b0;
		// pi/3
		send_write(`REG_ANGLE, sext(68629), 4'hf);
		held_r = rsp.bresp;
		check_hex("bresp", OKAY, held_r);
		for (i = 0; i < 4; i++) begin
			@(negedge clk);
			check_hex("bvalid", 32'd1, rsp.bvalid);
			check_hex("bresp", held_r, rsp.bresp);
		end
		req.bready = 1'b1;
		@(negedge clk);
		check_hex("bvalid", 32'd0, rsp.bvalid);
		wait_count(c + 16'd1);
		check_result(68629);
		check_angle(-68629);
		@(negedge clk);
		req.rready = 1'b0;
		send_read(`REG_COUNT);
		held_d = rsp.rdata;
		// count wraps at 16 bits
		check_hex("rdata", {16'd0, c + 16'd2}, held_d);
		for (i = 0; i < 4; i++) begin
			@(negedge clk);
			check_hex("rvalid", 32'd1, rsp.rvalid);
			check_hex("rdata", held_d, rsp.rdata);
		end
		req.rready = 1'b1;
		@(negedge clk);
		check_hex("rvalid", 32'd0, rsp.rvalid);
		check_angle(34315);
	endtask

	task automatic test_errors();
		logic [15:0] c;
		logic [15:0] c_after;
		logic [31:0] d;
		logic [1:0] r;
		get_count(c);
		axil_write(`REG_RESULT, 32'h0000_1234, 4'hf, r);
		check_hex("bresp", SLVERR, r);
		axil_write(4'hc, 32'h0000_1234, 4'hf, r);
		check_hex("bresp", SLVERR, r);
		axil_write(`REG_ANGLE, 32'h0000_1000, 4'h7, r);
		check_hex("bresp", SLVERR, r);
		// longer than the pipeline latency
		repeat (8) @(negedge clk);
		get_count(c_after);
		check_hex("count", c, c_after);
		axil_read(4'hc, d, r);
		check_hex("rresp", SLVERR, r);
		check_hex("rdata", 32'd0, d);
	endtask

	initial begin
		req = '0;
		req.bready = 1'b1;
		req.rready = 1'b1;
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_reset();
		// 0, pi/4, pi/2, -pi/2, pi
		check_angle(0);
		check_angle(51472);
		check_angle(102944);
		check_angle(-102944);
		check_angle(PI_Q);
		test_random(20);
		test_burst();
		test_backpressure();
		test_errors();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
sin_pkg.sv
fix_square.sv
fix_mult_const.sv
sin_pipe.sv
sin_axil_slave.sv
sin_top.sv
tb_sin_top.sv

// ==== Bender.yml ====
package:
  name: sin_axil

export_include_dirs:
  - .

sources:
  - files:
      - sin_pkg.sv
      - fix_square.sv
      - fix_mult_const.sv
      - sin_pipe.sv
      - sin_axil_slave.sv
      - sin_top.sv
  - target: test
    files:
      - tb_sin_top.sv
